/* design/driver_pkg.sv */
`default_nettype none

package driver_pkg;

    // Lane geometry
    localparam int NUM_FX              = 2;
    localparam int NUM_FY              = 3;
    localparam int NUM_LANES           = NUM_FX * NUM_FY;
    localparam int MASK_WORDS_PER_HALF = 8;
    localparam int BYTES_PER_LINE      = 16;
    localparam int WINDOW_BYTES        = 32;

    // Lines 0 and 1 come in through the load strobes
    localparam int FETCH_COUNT_INIT = 2;

    localparam int MASK_WIDTH = 16;
    localparam int BYTE_WIDTH = 8;
    localparam int LINE_WIDTH = 128;
    localparam int ADDR_WIDTH = 14;

    typedef logic [MASK_WIDTH-1:0] mask_word_t;
    typedef logic [BYTE_WIDTH-1:0] enc_byte_t;
    typedef logic [LINE_WIDTH-1:0] mem_line_t;
    typedef logic [ADDR_WIDTH-1:0] act_addr_t;

    // lane = fx*3 + fy
    typedef logic [2:0] lane_idx_t;
    typedef logic [NUM_LANES-1:0] lane_vec_t;

    // Bit lane*2 + half
    typedef logic [2*NUM_LANES-1:0] load_vec_t;

    // 0..16 bytes per step
    typedef logic [4:0] byte_count_t;
    typedef logic [3:0] byte_offset_t;

    typedef enum logic [2:0] {
        IDLE,
        SELECT,
        SHIFT_FIRST,
        FETCH,
        SHIFT_REST
    } driver_state_t;

endpackage

`default_nettype wire

/* design/line_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module line_loader (
    input  logic                  clk,
    input  logic                  arst_n_in,
    input  driver_pkg::mem_line_t masks_input,
    input  driver_pkg::mem_line_t encoded_input,
    input  driver_pkg::load_vec_t load_half,
    input  logic                  zero_padding,
    input  driver_pkg::lane_vec_t refill_en,
    output driver_pkg::mask_word_t load_mask_words [driver_pkg::MASK_WORDS_PER_HALF],
    output driver_pkg::enc_byte_t  load_bytes [driver_pkg::BYTES_PER_LINE],
    output driver_pkg::load_vec_t  lane_load_en,
    output driver_pkg::lane_vec_t  lane_refill_en
);
    import driver_pkg::*;

    logic      zero_padding_q;
    logic      pad_bytes;
    load_vec_t refill_halves;

    // Padding flag seen with the fetch request applies to the returning line
    always_ff @(posedge clk or negedge arst_n_in) begin
        if (!arst_n_in) begin
            zero_padding_q <= 1'b0;
        end else begin
            zero_padding_q <= zero_padding;
        end
    end

    assign pad_bytes = (|refill_en) ? zero_padding_q : zero_padding;

    // Most significant word first
    always_comb begin
        for (int i = 0; i < MASK_WORDS_PER_HALF; i++) begin
            load_mask_words[i] = zero_padding ? '0 :
                masks_input[LINE_WIDTH-1-MASK_WIDTH*i -: MASK_WIDTH];
        end
        for (int i = 0; i < BYTES_PER_LINE; i++) begin
            load_bytes[i] = pad_bytes ? '0 :
                encoded_input[LINE_WIDTH-1-BYTE_WIDTH*i -: BYTE_WIDTH];
        end
    end

    always_comb begin
        refill_halves = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            refill_halves[2*l+1] = refill_en[l];
        end
    end

    assign lane_load_en   = load_half;
    assign lane_refill_en = refill_en;

    // Refill and load share the byte path
    assert property (@(posedge clk) disable iff (!arst_n_in)
        (load_half & refill_halves) == '0);

endmodule

`default_nettype wire

/* design/lane_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_buffer (
    input  logic                       clk,
    input  logic                       arst_n_in,
    input  logic                       reset_driver,
    input  logic [1:0]                 load_en,
    input  logic                       refill_en,
    input  driver_pkg::mask_word_t     load_mask_words [driver_pkg::MASK_WORDS_PER_HALF],
    input  driver_pkg::enc_byte_t      load_bytes [driver_pkg::BYTES_PER_LINE],
    input  logic                       mask_pop,
    input  logic                       shift_en,
    input  driver_pkg::byte_count_t    shift_amount,
    output driver_pkg::mask_word_t     head_mask,
    output driver_pkg::enc_byte_t      window_head [driver_pkg::BYTES_PER_LINE],
    output driver_pkg::byte_offset_t   offset,
    output driver_pkg::act_addr_t      fetch_count
);
    import driver_pkg::*;

    localparam int MASK_WORDS = 2 * MASK_WORDS_PER_HALF;

    mask_word_t  mask_chain [MASK_WORDS];
    enc_byte_t   window [WINDOW_BYTES];
    enc_byte_t   shifted [WINDOW_BYTES];
    byte_count_t offset_sum;

    // Mask chain with the head at word 0
    always_ff @(posedge clk or negedge arst_n_in) begin
        if (!arst_n_in) begin
            for (int i = 0; i < MASK_WORDS; i++) begin
                mask_chain[i] <= '0;
            end
        end else if (mask_pop) begin
            for (int i = 0; i < MASK_WORDS - 1; i++) begin
                mask_chain[i] <= mask_chain[i+1];
            end
            mask_chain[MASK_WORDS-1] <= '0;
        end else begin
            for (int i = 0; i < MASK_WORDS_PER_HALF; i++) begin
                if (load_en[0]) begin
                    mask_chain[i] <= load_mask_words[i];
                end
                if (load_en[1]) begin
                    mask_chain[MASK_WORDS_PER_HALF+i] <= load_mask_words[i];
                end
            end
        end
    end

    // Window moves toward byte 0 while zeros enter at the top
    always_comb begin
        int src;
        for (int i = 0; i < WINDOW_BYTES; i++) begin
            src = i + int'(shift_amount);
            shifted[i] = (src < WINDOW_BYTES) ? window[src % WINDOW_BYTES] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (shift_en) begin
            window <= shifted;
        end else begin
            for (int i = 0; i < BYTES_PER_LINE; i++) begin
                if (load_en[0]) begin
                    window[i] <= load_bytes[i];
                end
                // Refill lands in the upper half only
                if (load_en[1] || refill_en) begin
                    window[BYTES_PER_LINE+i] <= load_bytes[i];
                end
            end
        end
    end

    assign offset_sum = byte_count_t'(offset) + shift_amount;

    // Offset wraps at the line boundary, which bumps the next fetch line
    always_ff @(posedge clk or negedge arst_n_in) begin
        if (!arst_n_in) begin
            offset      <= '0;
            fetch_count <= act_addr_t'(FETCH_COUNT_INIT);
        end else if (reset_driver) begin
            offset      <= '0;
            fetch_count <= act_addr_t'(FETCH_COUNT_INIT);
        end else if (shift_en) begin
            offset <= offset_sum[3:0];
            if (offset_sum >= byte_count_t'(BYTES_PER_LINE)) begin
                fetch_count <= fetch_count + act_addr_t'(1);
            end
        end
    end

    assign head_mask = mask_chain[0];

    always_comb begin
        for (int i = 0; i < BYTES_PER_LINE; i++) begin
            window_head[i] = window[i];
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n_in)
        shift_en |-> shift_amount <= byte_count_t'(BYTES_PER_LINE));

endmodule

`default_nettype wire

/* design/lane_drain.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_drain (
    input  logic                     clk,
    input  logic                     arst_n_in,
    input  driver_pkg::lane_idx_t    lane_sel,
    input  logic                     capture_out,
    input  logic                     latch_address,
    input  driver_pkg::act_addr_t    start_address,
    input  driver_pkg::mask_word_t   head_mask [driver_pkg::NUM_LANES],
    input  driver_pkg::enc_byte_t    window_head
                                         [driver_pkg::NUM_LANES][driver_pkg::BYTES_PER_LINE],
    input  driver_pkg::byte_offset_t offset [driver_pkg::NUM_LANES],
    input  driver_pkg::act_addr_t    fetch_count [driver_pkg::NUM_LANES],
    output driver_pkg::mask_word_t   masks_output,
    output driver_pkg::mem_line_t    encoded_output,
    output driver_pkg::byte_count_t  head_ones,
    output driver_pkg::byte_offset_t sel_offset,
    output driver_pkg::act_addr_t    fetch_address
);
    import driver_pkg::*;

    mask_word_t sel_mask;
    mem_line_t  packed_bytes;
    act_addr_t  start_q;

    assign sel_mask   = head_mask[lane_sel];
    assign sel_offset = offset[lane_sel];

    always_comb begin
        head_ones = '0;
        for (int i = 0; i < MASK_WIDTH; i++) begin
            head_ones = head_ones + byte_count_t'(sel_mask[i]);
        end
    end

    // First window byte goes to the top and unused bytes stay zero
    always_comb begin
        packed_bytes = '0;
        for (int i = 0; i < BYTES_PER_LINE; i++) begin
            if (i < int'(head_ones)) begin
                packed_bytes[LINE_WIDTH-1-BYTE_WIDTH*i -: BYTE_WIDTH] =
                    window_head[lane_sel][i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_in) begin
        if (!arst_n_in) begin
            masks_output   <= '0;
            encoded_output <= '0;
        end else if (capture_out) begin
            masks_output   <= sel_mask;
            encoded_output <= packed_bytes;
        end
    end

    // Held through the step
    always_ff @(posedge clk or negedge arst_n_in) begin
        if (!arst_n_in) begin
            start_q <= '0;
        end else if (latch_address) begin
            start_q <= start_address;
        end
    end

    assign fetch_address = start_q + fetch_count[lane_sel];

endmodule

`default_nettype wire

/* design/step_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module step_controller (
    input  logic                     clk,
    input  logic                     arst_n_in,
    input  logic                     start_driver,
    input  logic [1:0]               fx,
    input  logic [1:0]               fy,
    input  driver_pkg::byte_count_t  head_ones,
    input  driver_pkg::byte_offset_t sel_offset,
    output logic                     ready_driver,
    output logic                     fetch_request,
    output driver_pkg::lane_idx_t    lane_sel,
    output logic                     capture_out,
    output logic                     latch_address,
    output driver_pkg::lane_vec_t    mask_pop,
    output driver_pkg::lane_vec_t    shift_en,
    output driver_pkg::byte_count_t  shift_amount,
    output driver_pkg::lane_vec_t    refill_en
);
    import driver_pkg::*;

    driver_state_t state_q;
    driver_state_t state_d;
    logic [1:0]    fx_q;
    logic [1:0]    fy_q;
    byte_count_t   count_q;
    byte_count_t   room;
    logic          need_fetch;
    lane_vec_t     lane_onehot;

    always_ff @(posedge clk or negedge arst_n_in) begin
        if (!arst_n_in) begin
            state_q <= IDLE;
            fx_q    <= '0;
            fy_q    <= '0;
            count_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE) begin
                fx_q <= fx;
                fy_q <= fy;
            end
            if (state_q == SELECT) begin
                count_q <= head_ones;
            end else if (state_q == SHIFT_FIRST && need_fetch) begin
                // Left over for the shift after the refill
                count_q <= count_q - room;
            end
        end
    end

    assign lane_sel    = lane_idx_t'(3 * fx_q + fy_q);
    assign lane_onehot = lane_vec_t'(1) << lane_sel;

    // Bytes left before the current line runs out
    assign room       = byte_count_t'(BYTES_PER_LINE) - byte_count_t'(sel_offset);
    assign need_fetch = (count_q != '0) && (count_q >= room);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:        state_d = start_driver ? SELECT : IDLE;
            SELECT:      state_d = SHIFT_FIRST;
            SHIFT_FIRST: state_d = need_fetch ? FETCH : IDLE;
            FETCH:       state_d = (count_q != '0) ? SHIFT_REST : IDLE;
            SHIFT_REST:  state_d = IDLE;
            default:     state_d = IDLE;
        endcase
    end

    assign latch_address = (state_q == IDLE);
    assign capture_out   = (state_q == SELECT);
    assign ready_driver  = (state_q == SHIFT_FIRST);
    assign fetch_request = ready_driver && need_fetch;

    assign mask_pop  = ready_driver ? lane_onehot : '0;
    assign refill_en = (state_q == FETCH) ? lane_onehot : '0;
    assign shift_en  = ((ready_driver && count_q != '0) || state_q == SHIFT_REST) ?
                       lane_onehot : '0;

    assign shift_amount = (ready_driver && need_fetch) ? room : count_q;

    assert property (@(posedge clk) disable iff (!arst_n_in) fy_q != 2'd3);

endmodule

`default_nettype wire

/* design/sparse_driver_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sparse_driver_top (
    input  logic                   clk,
    input  logic                   arst_n_in,
    input  logic                   start_driver,
    input  logic                   reset_driver,
    input  logic [1:0]             fx,
    input  logic [1:0]             fy,
    input  driver_pkg::act_addr_t  start_address,
    input  logic                   zero_padding,
    input  driver_pkg::mem_line_t  encoded_input,
    input  driver_pkg::mem_line_t  masks_input,
    input  driver_pkg::load_vec_t  load_half,
    output logic                   ready_driver,
    output logic                   fetch_request,
    output driver_pkg::act_addr_t  fetch_address,
    output driver_pkg::mem_line_t  encoded_output,
    output driver_pkg::mask_word_t masks_output
);
    import driver_pkg::*;

    mask_word_t   load_mask_words [MASK_WORDS_PER_HALF];
    enc_byte_t    load_bytes [BYTES_PER_LINE];
    load_vec_t    lane_load_en;
    lane_vec_t    lane_refill_en;
    lane_vec_t    refill_en;
    lane_vec_t    mask_pop;
    lane_vec_t    shift_en;
    byte_count_t  shift_amount;
    lane_idx_t    lane_sel;
    logic         capture_out;
    logic         latch_address;
    byte_count_t  head_ones;
    byte_offset_t sel_offset;

    mask_word_t   head_mask [NUM_LANES];
    enc_byte_t    window_head [NUM_LANES][BYTES_PER_LINE];
    byte_offset_t offset [NUM_LANES];
    act_addr_t    fetch_count [NUM_LANES];

    line_loader u_loader (
        .clk            (clk),
        .arst_n_in      (arst_n_in),
        .masks_input    (masks_input),
        .encoded_input  (encoded_input),
        .load_half      (load_half),
        .zero_padding   (zero_padding),
        .refill_en      (refill_en),
        .load_mask_words(load_mask_words),
        .load_bytes     (load_bytes),
        .lane_load_en   (lane_load_en),
        .lane_refill_en (lane_refill_en)
    );

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        lane_buffer u_lane (
            .clk            (clk),
            .arst_n_in      (arst_n_in),
            .reset_driver   (reset_driver),
            .load_en        (lane_load_en[2*l +: 2]),
            .refill_en      (lane_refill_en[l]),
            .load_mask_words(load_mask_words),
            .load_bytes     (load_bytes),
            .mask_pop       (mask_pop[l]),
            .shift_en       (shift_en[l]),
            .shift_amount   (shift_amount),
            .head_mask      (head_mask[l]),
            .window_head    (window_head[l]),
            .offset         (offset[l]),
            .fetch_count    (fetch_count[l])
        );
    end

    lane_drain u_drain (
        .clk           (clk),
        .arst_n_in     (arst_n_in),
        .lane_sel      (lane_sel),
        .capture_out   (capture_out),
        .latch_address (latch_address),
        .start_address (start_address),
        .head_mask     (head_mask),
        .window_head   (window_head),
        .offset        (offset),
        .fetch_count   (fetch_count),
        .masks_output  (masks_output),
        .encoded_output(encoded_output),
        .head_ones     (head_ones),
        .sel_offset    (sel_offset),
        .fetch_address (fetch_address)
    );

    step_controller u_ctrl (
        .clk          (clk),
        .arst_n_in    (arst_n_in),
        .start_driver (start_driver),
        .fx           (fx),
        .fy           (fy),
        .head_ones    (head_ones),
        .sel_offset   (sel_offset),
        .ready_driver (ready_driver),
        .fetch_request(fetch_request),
        .lane_sel     (lane_sel),
        .capture_out  (capture_out),
        .latch_address(latch_address),
        .mask_pop     (mask_pop),
        .shift_en     (shift_en),
        .shift_amount (shift_amount),
        .refill_en    (refill_en)
    );

endmodule

`default_nettype wire

/* verif/tb_sparse_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sparse_driver;
    import driver_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int READY_TIMEOUT = 8;
    localparam int STREAM_DEPTH  = 512;
    localparam int MASK_DEPTH    = 16;

    logic       clk;
    logic       arst_n_in;
    logic       start_driver;
    logic       reset_driver;
    logic [1:0] fx;
    logic [1:0] fy;
    act_addr_t  start_address;
    logic       zero_padding;
    mem_line_t  encoded_input;
    mem_line_t  masks_input;
    load_vec_t  load_half;
    logic       ready_driver;
    logic       fetch_request;
    act_addr_t  fetch_address;
    mem_line_t  encoded_output;
    mask_word_t masks_output;

    // Reference model with one byte stream and mask queue per lane
    enc_byte_t  stream_mem [NUM_LANES][STREAM_DEPTH];
    int         stream_rd [NUM_LANES];
    int         stream_wr [NUM_LANES];
    mask_word_t mask_mem [NUM_LANES][MASK_DEPTH];
    int         mask_rd [NUM_LANES];
    int         model_offset [NUM_LANES];
    act_addr_t  model_count [NUM_LANES];
    act_addr_t  lane_start [NUM_LANES];

    int   errors;
    int   steps;
    logic aborted;

    sparse_driver_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Every address bit feeds each word
    function automatic mem_line_t memory_line(input act_addr_t addr);
        mem_line_t line;
        for (int i = 0; i < 8; i++) begin
            line[127-16*i -: 16] = 16'(addr) * 16'd40503 + 16'(i) * 16'd4099 + 16'h2b1f;
        end
        return line;
    endfunction

    function automatic mem_line_t load_line(input int lane, input int half);
        mem_line_t line;
        for (int i = 0; i < BYTES_PER_LINE; i++) begin
            line[127-8*i -: 8] = 8'(lane * 40 + half * 16 + i + 1);
        end
        return line;
    endfunction

    // Eight masks with the given ones counts, rotated so bit position varies
    function automatic mem_line_t mask_line(input int c0, input int c1, input int c2,
                                            input int c3, input int c4, input int c5,
                                            input int c6, input int c7);
        int         counts [8];
        mem_line_t  line;
        mask_word_t w;
        counts = '{c0, c1, c2, c3, c4, c5, c6, c7};
        for (int i = 0; i < 8; i++) begin
            w = 16'((32'h1 << counts[i]) - 1);
            line[127-16*i -: 16] = (w << i) | (w >> (16 - i));
        end
        return line;
    endfunction

    function automatic mem_line_t random_mask_line();
        mem_line_t line;
        for (int i = 0; i < 8; i++) begin
            if ($urandom_range(0, 7) == 0) begin
                line[127-16*i -: 16] = 16'hffff;
            end else begin
                line[127-16*i -: 16] = 16'($urandom) & 16'($urandom);
            end
        end
        return line;
    endfunction

    task automatic report_mismatch(input string what, input mem_line_t got,
                                   input mem_line_t exp);
        $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        errors++;
    endtask

    task automatic pulse_reset_driver();
        @(posedge clk);
        reset_driver <= 1'b1;
        @(posedge clk);
        reset_driver <= 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            model_offset[l] = 0;
            model_count[l]  = act_addr_t'(FETCH_COUNT_INIT);
        end
    endtask

    task automatic load_lane(input int lane, input mem_line_t m0, input mem_line_t m1,
                             input mem_line_t e0, input mem_line_t e1, input logic pad,
                             input act_addr_t start);
        @(posedge clk);
        masks_input   <= m0;
        encoded_input <= e0;
        zero_padding  <= pad;
        load_half     <= load_vec_t'(1) << (2 * lane);
        @(posedge clk);
        masks_input   <= m1;
        encoded_input <= e1;
        load_half     <= load_vec_t'(1) << (2 * lane + 1);
        @(posedge clk);
        load_half    <= '0;
        zero_padding <= 1'b0;
        for (int i = 0; i < 8; i++) begin
            mask_mem[lane][i]   = pad ? '0 : m0[127-16*i -: 16];
            mask_mem[lane][8+i] = pad ? '0 : m1[127-16*i -: 16];
        end
        for (int i = 0; i < BYTES_PER_LINE; i++) begin
            stream_mem[lane][i]    = pad ? '0 : e0[127-8*i -: 8];
            stream_mem[lane][16+i] = pad ? '0 : e1[127-8*i -: 8];
        end
        mask_rd[lane]    = 0;
        stream_rd[lane]  = 0;
        stream_wr[lane]  = WINDOW_BYTES;
        lane_start[lane] = start;
    endtask

    // Pop a mask, take its ones count in bytes, append a memory line on a crossing
    task automatic model_step(input int lane, output mask_word_t exp_mask,
                              output mem_line_t exp_line, output logic exp_fetch,
                              output act_addr_t exp_addr);
        int        n;
        mem_line_t line;
        exp_mask = '0;
        if (mask_rd[lane] < MASK_DEPTH) begin
            exp_mask = mask_mem[lane][mask_rd[lane]];
            mask_rd[lane]++;
        end
        n = $countones(exp_mask);
        exp_line = '0;
        for (int i = 0; i < n; i++) begin
            exp_line[127-8*i -: 8] = stream_mem[lane][stream_rd[lane]+i];
        end
        exp_fetch = (model_offset[lane] + n) >= BYTES_PER_LINE;
        exp_addr  = lane_start[lane] + model_count[lane];
        if (exp_fetch) begin
            line = memory_line(exp_addr);
            for (int i = 0; i < BYTES_PER_LINE; i++) begin
                stream_mem[lane][stream_wr[lane]+i] = line[127-8*i -: 8];
            end
            stream_wr[lane] += BYTES_PER_LINE;
            model_count[lane]++;
        end
        model_offset[lane] = (model_offset[lane] + n) % BYTES_PER_LINE;
        stream_rd[lane] += n;
    endtask

    task automatic run_step(input int lane, output logic fetched, output act_addr_t addr);
        mask_word_t exp_mask;
        mem_line_t  exp_line;
        logic       exp_fetch;
        act_addr_t  exp_addr;
        logic       seen;
        int         cycles;
        fetched = 1'b0;
        addr    = '0;
        if (aborted) return;
        model_step(lane, exp_mask, exp_line, exp_fetch, exp_addr);
        @(posedge clk);
        start_driver  <= 1'b1;
        fx            <= 2'(lane / 3);
        fy            <= 2'(lane % 3);
        start_address <= lane_start[lane];
        @(posedge clk);
        start_driver <= 1'b0;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            if (ready_driver) begin
                seen = 1'b1;
            end else begin
                if (fetch_request) report_mismatch("early fetch_request", 128'd1, 128'd0);
                cycles++;
            end
        end
        if (!seen) begin
            $display("Timeout: ready_driver did not rise within %0d cycles on lane %0d",
                     READY_TIMEOUT, lane);
            errors++;
            aborted = 1'b1;
            return;
        end
        steps++;
        fetched = fetch_request;
        addr    = fetch_address;
        if (masks_output !== exp_mask)
            report_mismatch("masks_output", mem_line_t'(masks_output), mem_line_t'(exp_mask));
        if (encoded_output !== exp_line)
            report_mismatch("encoded_output", encoded_output, exp_line);
        if (fetch_request !== exp_fetch)
            report_mismatch("fetch_request", mem_line_t'(fetch_request), mem_line_t'(exp_fetch));
        if (exp_fetch && fetch_address !== exp_addr)
            report_mismatch("fetch_address", mem_line_t'(fetch_address), mem_line_t'(exp_addr));
        // Memory answers in the cycle after the request
        @(posedge clk);
        if (fetched) encoded_input <= memory_line(addr);
        repeat (2) @(posedge clk);
    endtask

    task automatic reset_values();
        @(negedge clk);
        if ({ready_driver, fetch_request} !== 2'b00)
            report_mismatch("ready/fetch after reset",
                            mem_line_t'({ready_driver, fetch_request}), '0);
        if (masks_output !== '0)
            report_mismatch("masks_output after reset", mem_line_t'(masks_output), '0);
        if (encoded_output !== '0)
            report_mismatch("encoded_output after reset", encoded_output, '0);
    endtask

    task automatic single_short_step();
        logic      fetched;
        act_addr_t addr;
        pulse_reset_driver();
        load_lane(0, mask_line(5, 7, 4, 0, 16, 3, 9, 1), mask_line(2, 2, 2, 2, 2, 2, 2, 2),
                  load_line(0, 0), load_line(0, 1), 1'b0, 14'h0040);
        run_step(0, fetched, addr);
    endtask

    task automatic boundary_series();
        logic      fetched;
        act_addr_t addr;
        act_addr_t seen_addr [2];
        int        n_fetch;
        pulse_reset_driver();
        load_lane(4, mask_line(5, 7, 4, 0, 16, 3, 9, 1), mask_line(15, 15, 2, 11, 6, 16, 0, 8),
                  load_line(4, 0), load_line(4, 1), 1'b0, 14'h0100);
        n_fetch = 0;
        for (int i = 0; i < MASK_DEPTH; i++) begin
            run_step(4, fetched, addr);
            if (fetched && n_fetch < 2) seen_addr[n_fetch] = addr;
            if (fetched) n_fetch++;
        end
        if (n_fetch < 2) begin
            $display("Boundary series saw only %0d fetch requests", n_fetch);
            errors++;
        end else begin
            if (seen_addr[0] !== 14'h0102)
                report_mismatch("first fetch_address", mem_line_t'(seen_addr[0]), 128'h102);
            if (seen_addr[1] !== 14'h0103)
                report_mismatch("second fetch_address", mem_line_t'(seen_addr[1]), 128'h103);
        end
    endtask

    task automatic independent_lanes();
        logic      fetched;
        act_addr_t addr;
        pulse_reset_driver();
        load_lane(1, mask_line(9, 9, 9, 9, 9, 9, 9, 9), mask_line(4, 13, 1, 16, 7, 2, 10, 5),
                  load_line(1, 0), load_line(1, 1), 1'b0, 14'h0200);
        load_lane(5, mask_line(3, 12, 6, 14, 0, 8, 16, 2), mask_line(7, 7, 1, 1, 15, 4, 9, 3),
                  load_line(5, 0), load_line(5, 1), 1'b0, 14'h0300);
        for (int i = 0; i < 10; i++) begin
            run_step(1, fetched, addr);
            run_step(5, fetched, addr);
        end
        // Padded load on real data
        load_lane(2, mask_line(16, 16, 8, 8, 4, 4, 2, 2), mask_line(1, 1, 1, 1, 1, 1, 1, 1),
                  load_line(2, 0), load_line(2, 1), 1'b1, 14'h0400);
        run_step(2, fetched, addr);
        if (fetched !== 1'b0) report_mismatch("fetch on padded lane", 128'd1, 128'd0);
        for (int i = 0; i < 8; i++) begin
            run_step(5, fetched, addr);
        end
        if (fetched !== 1'b0) report_mismatch("fetch on exhausted lane", 128'd1, 128'd0);
    endtask

    task automatic driver_reset_restart();
        logic      fetched;
        act_addr_t addr;
        int        tries;
        pulse_reset_driver();
        load_lane(3, mask_line(12, 12, 12, 12, 12, 12, 12, 12),
                  mask_line(12, 12, 12, 12, 12, 12, 12, 12),
                  load_line(3, 0), load_line(3, 1), 1'b0, 14'h0500);
        repeat (3) run_step(3, fetched, addr);
        pulse_reset_driver();
        load_lane(3, mask_line(12, 12, 12, 12, 12, 12, 12, 12),
                  mask_line(12, 12, 12, 12, 12, 12, 12, 12),
                  load_line(3, 0), load_line(3, 1), 1'b0, 14'h0500);
        fetched = 1'b0;
        tries   = 0;
        while (!fetched && tries < 4 && !aborted) begin
            run_step(3, fetched, addr);
            tries++;
        end
        if (!fetched) begin
            $display("No fetch request seen after reset_driver and reload");
            errors++;
        end else if (addr !== 14'h0502) begin
            report_mismatch("fetch_address after reset_driver", mem_line_t'(addr), 128'h502);
        end
    endtask

    task automatic random_lane_steps();
        logic      fetched;
        act_addr_t addr;
        pulse_reset_driver();
        for (int l = 0; l < NUM_LANES; l++) begin
            load_lane(l, random_mask_line(), random_mask_line(),
                      {$urandom, $urandom, $urandom, $urandom},
                      {$urandom, $urandom, $urandom, $urandom}, 1'b0, act_addr_t'($urandom));
        end
        for (int i = 0; i < 90; i++) begin
            run_step(int'($urandom_range(0, NUM_LANES - 1)), fetched, addr);
        end
    endtask

    initial begin
        void'($urandom(32'h1084_88bd));
        errors        = 0;
        steps         = 0;
        aborted       = 1'b0;
        arst_n_in     = 1'b0;
        start_driver  = 1'b0;
        reset_driver  = 1'b0;
        fx            = '0;
        fy            = '0;
        start_address = '0;
        zero_padding  = 1'b0;
        encoded_input = '0;
        masks_input   = '0;
        load_half     = '0;
        repeat (5) @(posedge clk);
        arst_n_in <= 1'b1;
        reset_values();
        single_short_step();
        boundary_series();
        independent_lanes();
        driver_reset_restart();
        random_lane_steps();
        @(posedge clk);
        $display("Steps checked: %0d, errors: %0d", steps, errors);
        if (errors == 0 && !aborted) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
design/driver_pkg.sv
design/line_loader.sv
design/lane_buffer.sv
design/lane_drain.sv
design/step_controller.sv
design/sparse_driver_top.sv
verif/tb_sparse_driver.sv

/* Makefile */
# Verilator build and run for the sparse activation driver

VERILATOR ?= verilator
TOP       ?= tb_sparse_driver
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= Verification passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
